//--- build.f
design/axis_pkg.sv
design/agg_pkg.sv
design/header_buffer.sv
design/lane_adder.sv
design/agg_ctrl.sv
design/agg_top.sv
tests/tb_agg.sv

//--- design/agg_ctrl.sv
// ====================
// Aggregation FSM
// Checks vector indexes, drives all readies and picks the output source
// ====================
module agg_ctrl (
  input  logic                 axis_aclk,
  input  logic                 axis_resetn,
  input  logic                 s0_valid,
  input  logic                 s0_last,
  output logic                 s0_ready,
  input  logic                 s1_valid,
  input  logic                 s1_last,
  output logic                 s1_ready,
  input  logic                 hdr_full,
  input  agg_pkg::vec_index_t  idx0,
  input  agg_pkg::vec_index_t  idx1,
  input  axis_pkg::axis_beat_t hdr_beat,
  output logic                 take,
  output logic                 replay,
  output logic                 add_valid,
  input  logic                 add_ready,
  input  axis_pkg::axis_beat_t sum_beat,
  input  logic                 sum_valid,
  output logic                 sum_ready,
  output axis_pkg::axis_beat_t m,
  output logic                 m_valid,
  input  logic                 m_ready
);
  import agg_pkg::*;

  agg_state_t state;
  agg_state_t state_next;
  vec_index_t exp_idx;   // Next vector we accept
  hdr_count_t sent_cnt;  // Header beats sent on m
  logic       done0;     // Port 0 tlast taken, in AGGREGATE and DROP
  logic       done1;     // Port 1 tlast taken, DROP only
  logic       both_valid;
  logic       idx_match;
  logic       fin0;
  logic       fin1;

  assign both_valid = s0_valid && s1_valid;
  assign idx_match  = (idx0 == exp_idx) && (idx1 == exp_idx);

  // Port finished now or earlier while dropping
  assign fin0 = done0 || (s0_valid && s0_last);
  assign fin1 = done1 || (s1_valid && s1_last);

  always_comb begin
    state_next = state;
    take       = 1'b0;
    replay     = 1'b0;
    add_valid  = 1'b0;
    sum_ready  = 1'b0;
    s0_ready   = 1'b0;
    s1_ready   = 1'b0;
    m          = '0;
    m_valid    = 1'b0;
    case (state)
      COLLECT: begin
        take     = both_valid && !hdr_full;  // Lock step on both ports
        s0_ready = take;
        s1_ready = take;
        if (hdr_full) begin
          state_next = CHECK;
        end
      end
      CHECK: begin
        take       = !idx_match;  // Discard stored headers
        state_next = idx_match ? SEND_HEADER : DROP;
      end
      SEND_HEADER: begin
        m       = hdr_beat;
        m_valid = 1'b1;
        replay  = m_ready;
        if (m_ready && sent_cnt == hdr_count_t'(HDR_BEATS - 1)) begin
          state_next = AGGREGATE;
        end
      end
      AGGREGATE: begin
        add_valid = both_valid && !done0;
        s0_ready  = add_valid && add_ready;
        s1_ready  = add_valid && add_ready;
        m         = sum_beat;
        m_valid   = sum_valid;
        sum_ready = m_ready;
        if (sum_valid && m_ready && sum_beat.last) begin
          state_next = COLLECT;
        end
      end
      DROP: begin
        s0_ready = !done0;
        s1_ready = !done1;
        if (fin0 && fin1) begin
          state_next = COLLECT;
        end
      end
      default: state_next = COLLECT;
    endcase
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      state    <= COLLECT;
      exp_idx  <= '0;
      sent_cnt <= '0;
      done0    <= 1'b0;
      done1    <= 1'b0;
    end else begin
      state <= state_next;
      if (state == CHECK && idx_match) begin
        exp_idx <= exp_idx + 1'b1;
      end
      if (replay) begin
        sent_cnt <= (sent_cnt == hdr_count_t'(HDR_BEATS - 1)) ? '0 : sent_cnt + 1'b1;
      end
      if (state_next == COLLECT) begin
        done0 <= 1'b0;
        done1 <= 1'b0;
      end else if (state == AGGREGATE || state == DROP) begin
        if (s0_valid && s0_ready && s0_last) begin
          done0 <= 1'b1;  // Ends intake in AGGREGATE
        end
        if (state == DROP && s1_valid && s1_ready && s1_last) begin
          done1 <= 1'b1;
        end
      end
    end
  end

endmodule

//--- design/agg_pkg.sv
// ====================
// Aggregation protocol layout
// Header fields, lane types and controller states
// ====================
package agg_pkg;

  localparam int HDR_BEATS  = 320 / 64;  // Payload starts at bit 320
  localparam int LANE_WIDTH = 32;
  localparam int NUM_LANES  = 2;

  typedef logic [LANE_WIDTH-1:0]              lane_t;
  typedef logic [31:0]                        vec_index_t;
  typedef logic [$clog2(HDR_BEATS+1)-1:0]     hdr_count_t;

  // Bit offsets in the concatenated header, beat 0 at the bottom
  localparam int VEC_INDEX_POS  = 276;  // Stored byte reversed
  localparam int DEST_MAC_POS   = 0;
  localparam int DEST_MAC_WIDTH = 48;

  localparam logic [DEST_MAC_WIDTH-1:0] NEW_DEST_MAC = 48'hFFFF_FFFF_FFFF;  // Broadcast

  typedef enum logic [2:0] {
    COLLECT,
    CHECK,
    SEND_HEADER,
    AGGREGATE,
    DROP
  } agg_state_t;

endpackage

//--- design/agg_top.sv
// ====================
// Two-port vector aggregation element
// Sums matching packets from s0 and s1 onto the single output m
// ====================
module agg_top (
  input  logic                 axis_aclk,
  input  logic                 axis_resetn,
  input  axis_pkg::axis_beat_t s0,
  input  logic                 s0_valid,
  output logic                 s0_ready,
  input  axis_pkg::axis_beat_t s1,
  input  logic                 s1_valid,
  output logic                 s1_ready,
  output axis_pkg::axis_beat_t m,
  output logic                 m_valid,
  input  logic                 m_ready
);
  import axis_pkg::*;
  import agg_pkg::*;

  logic       take;
  logic       replay;
  logic       hdr_full;
  vec_index_t idx0;
  vec_index_t idx1;
  axis_beat_t hdr_beat;
  logic       add_valid;
  logic       add_ready;
  axis_beat_t sum_beat;
  logic       sum_valid;
  logic       sum_ready;

  header_buffer u_hdr (
    .axis_aclk, .axis_resetn, .in0(s0), .in1(s1), .take, .replay,
    .hdr_full, .idx0, .idx1, .hdr_beat
  );

  lane_adder u_add (
    .axis_aclk, .axis_resetn, .a(s0), .b(s1), .add_valid, .add_ready,
    .sum_beat, .sum_valid, .sum_ready
  );

  agg_ctrl u_ctrl (
    .axis_aclk, .axis_resetn,
    .s0_valid, .s0_last(s0.last), .s0_ready,
    .s1_valid, .s1_last(s1.last), .s1_ready,
    .hdr_full, .idx0, .idx1, .hdr_beat, .take, .replay,
    .add_valid, .add_ready, .sum_beat, .sum_valid, .sum_ready,
    .m, .m_valid, .m_ready
  );

endmodule

//--- design/axis_pkg.sv
// ====================
// Stream beat type and stream widths
// Imported by every block that carries beats
// ====================
package axis_pkg;

  localparam int DATA_WIDTH = 64;

  typedef logic [DATA_WIDTH-1:0] data_t;

  // One stream beat, valid and ready travel beside it
  typedef struct packed {
    data_t data;
    logic  last;
  } axis_beat_t;

endpackage

//--- design/header_buffer.sv
// ====================
// Header store for both input ports
// Captures headers in lock step, then replays port 0's with a broadcast MAC
// ====================
module header_buffer (
  input  logic                 axis_aclk,
  input  logic                 axis_resetn,
  input  axis_pkg::axis_beat_t in0,
  input  axis_pkg::axis_beat_t in1,
  input  logic                 take,
  input  logic                 replay,
  output logic                 hdr_full,
  output agg_pkg::vec_index_t  idx0,
  output agg_pkg::vec_index_t  idx1,
  output axis_pkg::axis_beat_t hdr_beat
);
  import axis_pkg::*;
  import agg_pkg::*;

  logic [HDR_BEATS*DATA_WIDTH-1:0] hdr0;
  logic [HDR_BEATS*DATA_WIDTH-1:0] hdr1;
  hdr_count_t                      cnt;  // Beats held
  data_t                           front_beat;

  assign hdr_full = (cnt == hdr_count_t'(HDR_BEATS));

  // A take on a full buffer discards the stored headers
  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      cnt <= '0;
    end else if (take) begin
      cnt <= hdr_full ? '0 : cnt + 1'b1;
    end else if (replay) begin
      cnt <= cnt - 1'b1;  // Reaches zero on the final header beat
    end
  end

  // New beats enter at the top so beat 0 ends up in the low bits
  always_ff @(posedge axis_aclk) begin
    if (take && !hdr_full) begin
      hdr0 <= {in0.data, hdr0[HDR_BEATS*DATA_WIDTH-1:DATA_WIDTH]};
      hdr1 <= {in1.data, hdr1[HDR_BEATS*DATA_WIDTH-1:DATA_WIDTH]};
    end else if (replay) begin
      hdr0 <= hdr0 >> DATA_WIDTH;  // Next header beat to the front
    end
  end

  // Index fields arrive in network byte order
  assign idx0 = {<<8{hdr0[VEC_INDEX_POS +: $bits(vec_index_t)]}};
  assign idx1 = {<<8{hdr1[VEC_INDEX_POS +: $bits(vec_index_t)]}};

  // Buffer is still full only while beat 0 sits at the front
  always_comb begin
    front_beat = hdr0[DATA_WIDTH-1:0];
    if (hdr_full) begin
      front_beat[DEST_MAC_POS +: DEST_MAC_WIDTH] = NEW_DEST_MAC;
    end
  end

  always_comb begin
    hdr_beat.data = front_beat;
    hdr_beat.last = 1'b0;  // Header never ends a packet
  end

endmodule

//--- design/lane_adder.sv
// ====================
// One-stage lane-wise integer adder
// Sums two payload beats lane by lane, with valid/ready on both sides
// ====================
module lane_adder (
  input  logic                 axis_aclk,
  input  logic                 axis_resetn,
  input  axis_pkg::axis_beat_t a,
  input  axis_pkg::axis_beat_t b,
  input  logic                 add_valid,
  output logic                 add_ready,
  output axis_pkg::axis_beat_t sum_beat,
  output logic                 sum_valid,
  input  logic                 sum_ready
);
  import axis_pkg::*;
  import agg_pkg::*;

  axis_beat_t sum_next;
  lane_t      lane_a;
  lane_t      lane_b;

  // Accept when empty or when the held beat leaves this cycle
  assign add_ready = !sum_valid || sum_ready;

  always_comb begin
    sum_next.data = '0;
    lane_a        = '0;
    lane_b        = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_a = a.data[i*LANE_WIDTH +: LANE_WIDTH];
      lane_b = b.data[i*LANE_WIDTH +: LANE_WIDTH];
      sum_next.data[i*LANE_WIDTH +: LANE_WIDTH] = lane_a + lane_b;  // Carry out dropped
    end
    sum_next.last = a.last;  // Port 0 marks the end
  end

  always_ff @(posedge axis_aclk) begin
    if (!axis_resetn) begin
      sum_valid <= 1'b0;
    end else if (add_ready) begin
      sum_valid <= add_valid;
    end
  end

  always_ff @(posedge axis_aclk) begin
    if (add_valid && add_ready) begin
      sum_beat <= sum_next;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the aggregation testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_agg -f build.f > build.log 2>&1 \
  || { cat build.log; echo "Compile failed"; exit 1; }
(./obj_dir/Vtb_agg || echo "Simulator exited with an error") > sim.log 2>&1
cat sim.log
grep -q "TEST FAIL" sim.log && { echo "Simulation failed"; exit 1; } \
  || grep -q "TEST PASS" sim.log

//--- tests/tb_agg.sv
// ====================
// Testbench for the two-port aggregation element
// Sends packet pairs with random gaps and checks m against a reference model
// ====================
module tb_agg;
  import axis_pkg::*;
  import agg_pkg::*;

  localparam int NUM_PKTS = 14;
  localparam int MAX_PAY  = 4;
  localparam int TIMEOUT  = 2000;  // Cycles per wait
  localparam int IDX_BEAT = 4;     // Bit 276 is bit 20 of beat 4
  localparam int IDX_BIT  = 20;

  logic       axis_aclk;
  logic       axis_resetn;
  axis_beat_t s0;
  logic       s0_valid;
  logic       s0_ready;
  axis_beat_t s1;
  logic       s1_valid;
  logic       s1_ready;
  axis_beat_t m;
  logic       m_valid;
  logic       m_ready;

  int         seed;
  data_t      hdr_a [NUM_PKTS][HDR_BEATS];
  data_t      hdr_b [NUM_PKTS][HDR_BEATS];
  data_t      pay_a [NUM_PKTS][MAX_PAY];
  data_t      pay_b [NUM_PKTS][MAX_PAY];
  int         pay_len [NUM_PKTS];
  vec_index_t ref_idx;
  axis_beat_t exp_q[$];
  string      exp_name[$];
  axis_beat_t got_q[$];
  bit         drv_done [2];

  agg_top dut0 (
    .axis_aclk, .axis_resetn, .s0, .s0_valid, .s0_ready,
    .s1, .s1_valid, .s1_ready, .m, .m_valid, .m_ready
  );

  always #50 axis_aclk = ~axis_aclk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [64:0] expected,
                             input logic [64:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s expected %h actual %h", name, expected, actual);
      fail_run("Output did not match the reference");
    end
  endtask

  function automatic vec_index_t byteswap(input vec_index_t x);
    return {x[7:0], x[15:8], x[23:16], x[31:24]};
  endfunction

  // Pairs 3 and 4 carry a wrong index and later pairs draw one at random
  function automatic void make_packets();
    vec_index_t next_idx;
    int         bad;
    next_idx = '0;
    for (int p = 0; p < NUM_PKTS; p++) begin
      bad = (p == 3) ? 1 : (p == 4) ? 2 : (p < 6) ? 0 : ($random(seed) & 3);
      pay_len[p] = 1 + ($random(seed) & 3);
      for (int k = 0; k < HDR_BEATS; k++) begin
        hdr_a[p][k] = {$random(seed), $random(seed)};
        hdr_b[p][k] = {$random(seed), $random(seed)};
      end
      hdr_a[p][IDX_BEAT][IDX_BIT +: 32] = byteswap(bad == 1 ? next_idx + 7 : next_idx);
      hdr_b[p][IDX_BEAT][IDX_BIT +: 32] = byteswap(bad == 2 ? next_idx + 3 : next_idx);
      if (bad == 0 || bad == 3) begin
        next_idx = next_idx + 1;
      end
      for (int k = 0; k < MAX_PAY; k++) begin
        pay_a[p][k] = {$random(seed), $random(seed)};
        pay_b[p][k] = {$random(seed), $random(seed)};
      end
      if (p % 2 == 1) begin  // Both lanes wrap past 2^32
        pay_a[p][0] = {32'hFFFF_FFFF, 32'hFFFF_FFF0};
        pay_b[p][0] = {32'h0000_0002, 32'h0000_0020};
      end
    end
  endfunction

  // Expected output of one pair or nothing when an index is off
  function automatic void build_expected(input int p);
    axis_beat_t beat;
    if (byteswap(hdr_a[p][IDX_BEAT][IDX_BIT +: 32]) != ref_idx ||
        byteswap(hdr_b[p][IDX_BEAT][IDX_BIT +: 32]) != ref_idx) begin
      return;
    end
    ref_idx = ref_idx + 1;
    for (int k = 0; k < HDR_BEATS; k++) begin
      beat.data = hdr_a[p][k];
      if (k == 0) begin
        beat.data[47:0] = '1;  // Broadcast destination MAC
      end
      beat.last = 1'b0;
      exp_q.push_back(beat);
      exp_name.push_back($sformatf("pair %0d header beat %0d", p, k));
    end
    for (int k = 0; k < pay_len[p]; k++) begin
      beat.data[31:0]  = pay_a[p][k][31:0] + pay_b[p][k][31:0];
      beat.data[63:32] = pay_a[p][k][63:32] + pay_b[p][k][63:32];
      beat.last        = (k == pay_len[p] - 1);
      exp_q.push_back(beat);
      exp_name.push_back($sformatf("pair %0d payload beat %0d", p, k));
    end
  endfunction

  function automatic axis_beat_t get_beat(input int port, input int p, input int k);
    axis_beat_t beat;
    if (k < HDR_BEATS) begin
      beat.data = (port == 0) ? hdr_a[p][k] : hdr_b[p][k];
      beat.last = 1'b0;
    end else begin
      beat.data = (port == 0) ? pay_a[p][k - HDR_BEATS] : pay_b[p][k - HDR_BEATS];
      beat.last = (k == HDR_BEATS + pay_len[p] - 1);
    end
    return beat;
  endfunction

  task automatic set_port(input int port, input axis_beat_t beat, input logic valid);
    if (port == 0) begin
      s0       = beat;
      s0_valid = valid;
    end else begin
      s1       = beat;
      s1_valid = valid;
    end
  endtask

  task automatic send_stream(input int port);
    int   gap;
    int   wait_cnt;
    logic moved;
    for (int p = 0; p < NUM_PKTS; p++) begin
      for (int k = 0; k < HDR_BEATS + pay_len[p]; k++) begin
        gap = $random(seed) & 7;
        gap = (gap > 2) ? 0 : gap;
        for (int i = 0; i < gap; i++) begin
          set_port(port, '0, 1'b0);
          @(posedge axis_aclk);
          #1;
        end
        set_port(port, get_beat(port, p, k), 1'b1);
        wait_cnt = 0;
        moved    = 1'b0;
        while (!moved) begin
          @(negedge axis_aclk);  // Ready is settled here
          moved = (port == 0) ? s0_ready : s1_ready;
          @(posedge axis_aclk);
          #1;
          wait_cnt++;
          if (wait_cnt > TIMEOUT) begin
            fail_run($sformatf("Port %0d was never ready for its next beat", port));
          end
        end
      end
    end
    set_port(port, '0, 1'b0);
    drv_done[port] = 1'b1;
  endtask

  // Random back-pressure and collection of transferred beats
  task automatic watch_output();
    forever begin
      @(posedge axis_aclk);
      #1;
      m_ready = (($random(seed) & 3) != 0);
      @(negedge axis_aclk);
      if (m_valid && m_ready) begin
        got_q.push_back(m);
      end
    end
  endtask

  initial begin
    int wait_cnt;
    axis_aclk   = 1'b0;
    axis_resetn = 1'b0;
    s0          = '0;
    s0_valid    = 1'b0;
    s1          = '0;
    s1_valid    = 1'b0;
    m_ready     = 1'b0;
    seed        = 14;
    ref_idx     = '0;
    make_packets();
    for (int p = 0; p < NUM_PKTS; p++) begin
      build_expected(p);
    end
    repeat (5) @(posedge axis_aclk);
    #1;
    axis_resetn = 1'b1;
    for (int i = 0; i < 5; i++) begin
      @(negedge axis_aclk);
      check_value("idle m_valid", '0, 65'(m_valid));
      check_value("idle s0_ready", '0, 65'(s0_ready));
      check_value("idle s1_ready", '0, 65'(s1_ready));
    end
    @(posedge axis_aclk);
    #1;
    fork
      send_stream(0);
      send_stream(1);
      watch_output();
    join_none
    while (exp_q.size() > 0) begin
      wait_cnt = 0;
      while (got_q.size() == 0) begin
        @(posedge axis_aclk);
        wait_cnt++;
        if (wait_cnt > TIMEOUT) begin
          fail_run("No output beat arrived in time");
        end
      end
      check_value(exp_name.pop_front(), exp_q.pop_front(), got_q.pop_front());
    end
    wait_cnt = 0;
    while (!(drv_done[0] && drv_done[1])) begin
      @(posedge axis_aclk);
      wait_cnt++;
      if (wait_cnt > TIMEOUT) begin
        fail_run("Input packets were not all consumed");
      end
    end
    for (int i = 0; i < 20; i++) begin
      @(posedge axis_aclk);  // Quiet time to catch extra beats
    end
    if (got_q.size() == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      fail_run("Output carried beats beyond the expected stream");
    end
  end

endmodule
